// File: source/lane_params.svh
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// AXI4-Lite byte address width
`define LANE_AXI_AW 4

// symbols per comma slot, power of two
`define LANE_COMMA_PERIOD 16

// error and symbol counter width
`define LANE_CNT_W 16

`endif

// File: source/lane_pkg.sv
`default_nettype none
`include "lane_params.svh"

package lane_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [9:0] sym10_t;                 // abcdei fghj, a in bit 9
  typedef logic [`LANE_CNT_W-1:0] cnt_t;
  typedef enum logic {HUNT, LOCKED} mon_state_t;

  localparam logic [8:0] K28_5     = {1'b1, 8'hBC};   // {k, byte}
  localparam sym10_t     K28_5_RDM = 10'b0011111010;  // rd+ form is the complement

  // codes for negative running disparity
  localparam logic [5:0] ENC6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };
  localparam logic [3:0] ENC4 [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

endpackage

`default_nettype wire

// File: source/lane_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module lane_csr (
  input  logic                    tx_pclk,
  input  logic                    arst_n,
  input  logic [`LANE_AXI_AW-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`LANE_AXI_AW-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    enable,
  output logic                    inject,
  output logic                    clear,
  input  logic                    locked,
  input  lane_pkg::cnt_t          err_count,
  input  lane_pkg::cnt_t          sym_count
);

  localparam logic [`LANE_AXI_AW-1:0] ADDR_CTRL   = `LANE_AXI_AW'('h0);
  localparam logic [`LANE_AXI_AW-1:0] ADDR_STATUS = `LANE_AXI_AW'('h4);
  localparam logic [`LANE_AXI_AW-1:0] ADDR_ERR    = `LANE_AXI_AW'('h8);
  localparam logic [`LANE_AXI_AW-1:0] ADDR_SYM    = `LANE_AXI_AW'('hC);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic        wr_fire;
  logic        rd_fire;
  logic        wr_hit;
  logic        rd_hit;
  logic        ctrl_wr;
  logic [31:0] rd_mux;

  assign wr_fire = awvalid & wvalid & ~bvalid;   // both channels together
  assign rd_fire = arvalid & ~rvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign arready = rd_fire;

  assign wr_hit  = (awaddr == ADDR_CTRL) || (awaddr == ADDR_STATUS) ||
                   (awaddr == ADDR_ERR) || (awaddr == ADDR_SYM);
  assign ctrl_wr = wr_fire && (awaddr == ADDR_CTRL) && wstrb[0];

  always_comb begin
    rd_hit = 1'b1;
    case (araddr)
      ADDR_CTRL:   rd_mux = {31'b0, enable};     // inject, clear read 0
      ADDR_STATUS: rd_mux = {31'b0, locked};
      ADDR_ERR:    rd_mux = 32'(err_count);
      ADDR_SYM:    rd_mux = 32'(sym_count);
      default: begin
        rd_mux = '0;
        rd_hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge tx_pclk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
      inject <= 1'b0;
      clear  <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      inject <= ctrl_wr & wdata[1];   // single cycle pulses
      clear  <= ctrl_wr & wdata[2];
      if (ctrl_wr) enable <= wdata[0];
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rd_fire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  // response payload, held while waiting for ready
  always_ff @(posedge tx_pclk) begin
    if (wr_fire) bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    if (rd_fire) begin
      rdata <= rd_mux;
      rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: source/lane_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module lane_pattern_gen (
  input  logic            tx_pclk,
  input  logic            arst_n,
  input  logic            enable,
  output lane_pkg::byte_t data,
  output logic            is_k,
  output logic            valid
);

  localparam lane_pkg::byte_t SLOT_MASK = lane_pkg::byte_t'(`LANE_COMMA_PERIOD - 1);

  lane_pkg::byte_t count;

  always_ff @(posedge tx_pclk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= enable;
      if (enable) count <= count + 8'd1;   // holds while disabled
    end
  end

  always_ff @(posedge tx_pclk) begin
    if ((count & SLOT_MASK) == '0) {is_k, data} <= lane_pkg::K28_5;
    else {is_k, data} <= {1'b0, count};
  end

endmodule

`default_nettype wire

// File: source/lane_enc_8b10b.sv
`timescale 1ns/1ps
`default_nettype none

module lane_enc_8b10b (
  input  logic             tx_pclk,
  input  logic             arst_n,
  input  lane_pkg::byte_t  data,
  input  logic             is_k,
  input  logic             valid,
  input  logic             inject,
  output lane_pkg::sym10_t sym,
  output logic             sym_valid
);

  logic             rd;        // 1 = positive
  logic             rd6;
  logic             rd_next;
  logic             armed;
  logic             a7;
  logic [4:0]       x;
  logic [2:0]       y;
  logic [5:0]       c6_m;
  logic [5:0]       c6;
  logic [3:0]       c4_m;
  logic [3:0]       c4;
  lane_pkg::sym10_t code;

  assign x = data[4:0];
  assign y = data[7:5];

  always_comb begin
    c6_m = lane_pkg::ENC6[x];
    rd6  = ($countones(c6_m) != 3) ? ~rd : rd;
    c6   = (rd && ($countones(c6_m) != 3 || c6_m == 6'b111000)) ? ~c6_m : c6_m;
    // alternate D.x.7 avoids a run of five
    a7   = (y == 3'd7) && ((!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                           (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
    c4_m = a7 ? 4'b0111 : lane_pkg::ENC4[y];
    c4   = (rd6 && ($countones(c4_m) != 2 || c4_m == 4'b1100)) ? ~c4_m : c4_m;
    rd_next = ($countones(c4_m) != 2) ? ~rd6 : rd6;
    code = {c6, c4};
    if (is_k) begin
      code    = rd ? ~lane_pkg::K28_5_RDM : lane_pkg::K28_5_RDM;
      rd_next = ~rd;   // comma is unbalanced
    end
  end

  always_ff @(posedge tx_pclk or negedge arst_n) begin
    if (!arst_n) begin
      rd        <= 1'b0;
      armed     <= 1'b0;
      sym_valid <= 1'b0;
    end else begin
      sym_valid <= valid;
      if (valid) rd <= rd_next;   // tracks the clean code
      armed <= inject | (armed & ~(valid & ~is_k));
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (valid) sym <= code ^ {9'b0, armed & ~is_k};   // flip j on error injection
  end

endmodule

`default_nettype wire

// File: source/lane_dec_8b10b.sv
`timescale 1ns/1ps
`default_nettype none

module lane_dec_8b10b (
  input  logic             tx_pclk,
  input  logic             arst_n,
  input  lane_pkg::sym10_t sym,
  input  logic             sym_valid,
  output lane_pkg::byte_t  data,
  output logic             is_k,
  output logic             code_err,
  output logic             disp_err,
  output logic             valid
);

  logic       rd;
  logic       rd6;
  logic       rd_next;
  logic [5:0] c6;
  logic [3:0] c4;
  logic [4:0] d5;
  logic [2:0] d3;
  logic       hit6;
  logic       hit4;
  logic       comma;
  logic       disp_bad;
  int         n6;
  int         n4;

  assign c6    = sym[9:4];
  assign c4    = sym[3:0];
  assign n6    = $countones(c6);
  assign n4    = $countones(c4);
  assign comma = (sym == lane_pkg::K28_5_RDM) || (sym == ~lane_pkg::K28_5_RDM);

  // reverse lookup against both polarities of each code
  always_comb begin
    hit6 = 1'b0;
    d5   = '0;
    hit4 = 1'b0;
    d3   = '0;
    for (int i = 0; i < 32; i++) begin
      if (c6 == lane_pkg::ENC6[i] || (c6 == ~lane_pkg::ENC6[i] &&
          ($countones(lane_pkg::ENC6[i]) != 3 || lane_pkg::ENC6[i] == 6'b111000))) begin
        hit6 = 1'b1;
        d5   = 5'(i);
      end
    end
    for (int j = 0; j < 8; j++) begin
      if (c4 == lane_pkg::ENC4[j] || (c4 == ~lane_pkg::ENC4[j] &&
          ($countones(lane_pkg::ENC4[j]) != 2 || lane_pkg::ENC4[j] == 4'b1100))) begin
        hit4 = 1'b1;
        d3   = 3'(j);
      end
    end
    if (c4 == 4'b0111 || c4 == 4'b1000) begin   // alternate x.7
      hit4 = 1'b1;
      d3   = 3'd7;
    end
  end

  // follow the line, resync on every unbalanced sub-block
  assign rd6      = (n6 > 3) ? 1'b1 : (n6 < 3) ? 1'b0 : rd;
  assign rd_next  = (n4 > 2) ? 1'b1 : (n4 < 2) ? 1'b0 : rd6;
  assign disp_bad = ((n6 > 3 || c6 == 6'b111000) && rd) ||
                    ((n6 < 3 || c6 == 6'b000111) && !rd) ||
                    ((n4 > 2 || c4 == 4'b1100) && rd6) ||
                    ((n4 < 2 || c4 == 4'b0011) && !rd6);

  always_ff @(posedge tx_pclk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
      rd    <= 1'b0;
    end else begin
      valid <= sym_valid;
      if (sym_valid) rd <= rd_next;
    end
  end

  always_ff @(posedge tx_pclk) begin
    if (sym_valid) begin
      {is_k, data} <= comma ? lane_pkg::K28_5 : {1'b0, d3, d5};
      code_err     <= !comma && !(hit6 && hit4);
      disp_err     <= disp_bad;
    end
  end

endmodule

`default_nettype wire

// File: source/lane_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module lane_monitor (
  input  logic            tx_pclk,
  input  logic            arst_n,
  input  lane_pkg::byte_t data,
  input  logic            is_k,
  input  logic            code_err,
  input  logic            disp_err,
  input  logic            valid,
  input  logic            clear,
  output logic            locked,
  output lane_pkg::cnt_t  err_count,
  output lane_pkg::cnt_t  sym_count
);

  lane_pkg::mon_state_t state;
  lane_pkg::byte_t      exp_byte;
  logic                 seeded;   // expected value is live
  logic                 bad;
  logic                 err_inc;
  logic                 sym_inc;

  assign locked  = (state == lane_pkg::LOCKED);
  assign bad     = code_err | disp_err;
  assign err_inc = valid && locked && (bad || (!is_k && seeded && data != exp_byte));
  assign sym_inc = valid && locked && !bad && !is_k && (!seeded || data == exp_byte);

  always_ff @(posedge tx_pclk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= lane_pkg::HUNT;
      seeded    <= 1'b0;
      err_count <= '0;
      sym_count <= '0;
    end else begin
      if (valid && !locked && is_k && !bad) begin
        state  <= lane_pkg::LOCKED;
        seeded <= 1'b0;
      end else if (valid && locked && bad) state <= lane_pkg::HUNT;
      else if (valid && locked && !is_k) seeded <= 1'b1;
      if (clear) err_count <= '0;
      else if (err_inc && err_count != '1) err_count <= err_count + 1'b1;   // saturate
      if (clear) sym_count <= '0;
      else if (sym_inc && sym_count != '1) sym_count <= sym_count + 1'b1;
    end
  end

  // advances every symbol, commas included
  always_ff @(posedge tx_pclk) begin
    if (valid && locked && !bad) exp_byte <= (!is_k && !seeded) ? data + 8'd1 : exp_byte + 8'd1;
  end

endmodule

`default_nettype wire

// File: source/lane_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module lane_loopback_top (
  input  logic                    tx_pclk,
  input  logic                    arst_n,
  input  logic [`LANE_AXI_AW-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [31:0]             wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`LANE_AXI_AW-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [31:0]             rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  logic             enable, inject, clear, locked;
  logic             gen_k, gen_valid, sym_valid;
  logic             dec_k, code_err, disp_err, dec_valid;
  lane_pkg::byte_t  gen_data, dec_data;
  lane_pkg::sym10_t sym;
  lane_pkg::cnt_t   err_count, sym_count;

  lane_csr u_lane_csr (.*);

  lane_pattern_gen u_lane_pattern_gen (.tx_pclk, .arst_n, .enable,
    .data(gen_data), .is_k(gen_k), .valid(gen_valid));

  lane_enc_8b10b u_lane_enc_8b10b (.tx_pclk, .arst_n, .data(gen_data), .is_k(gen_k),
    .valid(gen_valid), .inject, .sym, .sym_valid);

  // internal loopback, symbol aligned
  lane_dec_8b10b u_lane_dec_8b10b (.tx_pclk, .arst_n, .sym, .sym_valid, .data(dec_data),
    .is_k(dec_k), .code_err, .disp_err, .valid(dec_valid));

  lane_monitor u_lane_monitor (.tx_pclk, .arst_n, .data(dec_data), .is_k(dec_k), .code_err,
    .disp_err, .valid(dec_valid), .clear, .locked, .err_count, .sym_count);

endmodule

`default_nettype wire

// File: bench/lane_csr_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module lane_csr_assertions (
  input logic        tx_pclk,
  input logic        arst_n,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic        inject,
  input logic        clear
);

  // responses hold until taken
  a_bvalid_hold: assert property (@(posedge tx_pclk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
  a_rvalid_hold: assert property (@(posedge tx_pclk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");
  a_rdata_stable: assert property (@(posedge tx_pclk) disable iff (!arst_n)
    rvalid && !rready |=> $stable(rdata)) else $error("rdata changed while rvalid waited");

  a_inject_pulse: assert property (@(posedge tx_pclk) disable iff (!arst_n)
    inject |=> !inject) else $error("inject high two cycles in a row");
  a_clear_pulse: assert property (@(posedge tx_pclk) disable iff (!arst_n)
    clear |=> !clear) else $error("clear high two cycles in a row");

endmodule

`default_nettype wire

// File: bench/lane_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lane_params.svh"

module lane_loopback_tb;

  localparam int P = `LANE_COMMA_PERIOD;
  localparam logic [`LANE_AXI_AW-1:0] CTRL   = 'h0;
  localparam logic [`LANE_AXI_AW-1:0] STATUS = 'h4;
  localparam logic [`LANE_AXI_AW-1:0] ERR    = 'h8;
  localparam logic [`LANE_AXI_AW-1:0] SYM    = 'hC;
  localparam logic [1:0]  OKAY   = 2'b00;
  localparam logic [1:0]  SLVERR = 2'b10;
  localparam logic [31:0] ALL    = 32'hFFFF_FFFF;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_DELTA, OP_WAIT} op_t;
  typedef struct packed {
    op_t                     kind;
    logic [`LANE_AXI_AW-1:0] off;
    logic [31:0]             wd;     // write data, or cycles for a wait
    logic [31:0]             want;
    logic [31:0]             mask;
    logic [31:0]             lo;
    logic [31:0]             hi;
    logic [1:0]              resp;
  } row_t;

  logic                    tx_pclk;
  logic                    arst_n;
  logic [`LANE_AXI_AW-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [31:0]             wdata;
  logic [3:0]              wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`LANE_AXI_AW-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [31:0]             rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;

  row_t        rows[$];
  int unsigned cyc;
  int unsigned rd_cycle;
  int unsigned last_cycle;
  logic [31:0] last_data;
  int unsigned limit_cycles;

  lane_loopback_top u_lane_loopback_top (.*);

  bind lane_csr lane_csr_assertions u_lane_csr_assertions (.tx_pclk, .arst_n, .bvalid,
    .bready, .rvalid, .rready, .rdata, .inject, .clear);

  always #20 tx_pclk = ~tx_pclk;

  always @(posedge tx_pclk) cyc <= cyc + 1;

  task automatic report_value(input string sig, input logic [31:0] want, act);
    $display("[FAIL] %0t ns %s: expected 0x%0h, actual 0x%0h", $time, sig, want, act);
    $display("TB FAILED");
    $fatal(1, "value mismatch on %s", sig);
  endtask

  task automatic report_range(input string sig, input logic [31:0] lo, hi, act);
    $display("[FAIL] %0t ns %s: expected 0x%0h..0x%0h, actual 0x%0h", $time, sig, lo, hi, act);
    $display("TB FAILED");
    $fatal(1, "value out of range on %s", sig);
  endtask

  task automatic axi_write(input logic [`LANE_AXI_AW-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int unsigned dly;
    dly = $urandom % 4;
    @(posedge tx_pclk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    do @(posedge tx_pclk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    repeat (dly) @(posedge tx_pclk);   // slow master on b
    bready <= 1'b1;
    do @(posedge tx_pclk); while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`LANE_AXI_AW-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int unsigned dly;
    dly = $urandom % 4;
    @(posedge tx_pclk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge tx_pclk); while (!arready);
    rd_cycle = cyc;   // value is captured on this edge
    arvalid <= 1'b0;
    repeat (dly) @(posedge tx_pclk);
    rready <= 1'b1;
    do @(posedge tx_pclk); while (!rvalid);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic push_row(input op_t kind, input logic [`LANE_AXI_AW-1:0] off,
                          input logic [31:0] wd, want, mask, lo, hi, input logic [1:0] resp);
    rows.push_back({kind, off, wd, want, mask, lo, hi, resp});
  endtask

  task automatic build_table();
    push_row(OP_RD, CTRL, 0, 0, ALL, 0, ALL, OKAY);      // reset values
    push_row(OP_RD, STATUS, 0, 0, ALL, 0, ALL, OKAY);
    push_row(OP_RD, ERR, 0, 0, ALL, 0, ALL, OKAY);
    push_row(OP_RD, SYM, 0, 0, ALL, 0, ALL, OKAY);
    push_row(OP_WR, CTRL, 32'h1, 0, 0, 0, 0, OKAY);      // enable
    push_row(OP_WAIT, 0, 3 * P, 0, 0, 0, 0, OKAY);
    push_row(OP_RD, STATUS, 0, 1, 32'h1, 0, ALL, OKAY);
    push_row(OP_RD, ERR, 0, 0, ALL, 0, ALL, OKAY);
    push_row(OP_RD, CTRL, 0, 1, ALL, 0, ALL, OKAY);
    push_row(OP_RD, SYM, 0, 0, 0, 1, ALL, OKAY);
    push_row(OP_WAIT, 0, 2 * P, 0, 0, 0, 0, OKAY);
    push_row(OP_DELTA, SYM, 0, 0, 0, 1, ALL, OKAY);
    push_row(OP_WR, CTRL, 32'h3, 0, 0, 0, 0, OKAY);      // one bit error
    push_row(OP_WAIT, 0, 2 * P, 0, 0, 0, 0, OKAY);
    push_row(OP_RD, ERR, 0, 0, 0, 1, 2, OKAY);
    push_row(OP_RD, STATUS, 0, 1, 32'h1, 0, ALL, OKAY);
    push_row(OP_RD, CTRL, 0, 1, ALL, 0, ALL, OKAY);
    push_row(OP_WR, CTRL, 32'h5, 0, 0, 0, 0, OKAY);      // clear counters
    push_row(OP_RD, ERR, 0, 0, ALL, 0, ALL, OKAY);
    push_row(OP_WR, CTRL, 32'h0, 0, 0, 0, 0, OKAY);
    push_row(OP_WAIT, 0, 8, 0, 0, 0, 0, OKAY);           // let the pipe drain
    push_row(OP_RD, SYM, 0, 0, 0, 0, ALL, OKAY);
    push_row(OP_WAIT, 0, P, 0, 0, 0, 0, OKAY);
    push_row(OP_DELTA, SYM, 0, 0, 0, 0, 0, OKAY);
    push_row(OP_RD, 'h1, 0, 0, 0, 0, ALL, SLVERR);       // unmapped offsets
    push_row(OP_RD, 'h6, 0, 0, 0, 0, ALL, SLVERR);
    push_row(OP_WR, 'h1, 32'h1, 0, 0, 0, 0, SLVERR);
    push_row(OP_WR, 'hA, 32'h1, 0, 0, 0, 0, SLVERR);
    push_row(OP_RD, CTRL, 0, 0, ALL, 0, ALL, OKAY);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] delta;
    logic [31:0] bound;
    repeat ($urandom % 4) @(posedge tx_pclk);   // idle gap
    case (r.kind)
      OP_WAIT: repeat (r.wd) @(posedge tx_pclk);
      OP_WR: begin
        axi_write(r.off, r.wd, resp);
        assert (resp == r.resp) else report_value("bresp", 32'(r.resp), 32'(resp));
      end
      default: begin
        axi_read(r.off, data, resp);
        assert (resp == r.resp) else report_value("rresp", 32'(r.resp), 32'(resp));
        assert ((data & r.mask) == r.want) else report_value("rdata", r.want, data & r.mask);
        if (r.kind == OP_DELTA) begin
          delta = data - last_data;
          // at most one count per cycle between the two captures, plus slack
          bound = (rd_cycle - last_cycle + 2 < r.hi) ? rd_cycle - last_cycle + 2 : r.hi;
          assert (delta >= r.lo && delta <= bound)
            else report_range("rdata delta", r.lo, bound, delta);
        end else begin
          assert (data >= r.lo && data <= r.hi) else report_range("rdata", r.lo, r.hi, data);
        end
        last_data  = data;
        last_cycle = rd_cycle;
      end
    endcase
  endtask

  initial begin
    int unsigned longest;
    void'($urandom(95344));
    tx_pclk = 1'b0;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    cyc     = 0;
    build_table();
    longest = 0;
    foreach (rows[i]) if (rows[i].kind == OP_WAIT && rows[i].wd > longest) longest = rows[i].wd;
    limit_cycles = rows.size() * (longest + 16) + 20;
    repeat (3) @(posedge tx_pclk);
    arst_n <= 1'b1;
    foreach (rows[i]) run_row(rows[i]);
    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles != 0);
    #(limit_cycles * 40);
    $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/lane_pkg.sv
source/lane_csr.sv
source/lane_pattern_gen.sv
source/lane_enc_8b10b.sv
source/lane_dec_8b10b.sv
source/lane_monitor.sv
source/lane_loopback_top.sv
bench/lane_csr_assertions.sv
bench/lane_loopback_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lane loopback testbench; exit status is the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f project.f \
  --top-module lane_loopback_tb -o lane_loopback_sim

./obj_dir/lane_loopback_sim
